// File: project.f
rtl/vga_pkg.sv
rtl/vga_regs.sv
rtl/vga_pclk_div.sv
rtl/vga_axis_timer.sv
rtl/vga_pixel_out.sv
rtl/vga_top.sv
bench/vga_tb_sva.sv
bench/vga_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= vga_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/vga_tb.sv
// Directed testbench for the display controller top level.
// Inputs change on the falling clock edge, outputs are sampled there too.
// Timing checks skip the first sync pulse after enable, which is one clock short.
// The pixel source answers every strobe with a fresh xorshift word.
`timescale 1ns/100ps
`default_nettype none

module vga_tb;

  localparam int          CLK_PERIOD = 20;
  localparam logic [31:0] SEED       = 32'h97453714;

  // register byte addresses
  localparam logic [5:0] A_CTRL = 6'h00;
  localparam logic [5:0] A_HVVL = 6'h04;
  localparam logic [5:0] A_HTIM = 6'h08;
  localparam logic [5:0] A_VTIM = 6'h0C;
  localparam logic [5:0] A_STAT = 6'h10;

  // defined bits of the control and timing words
  localparam logic [31:0] CTRL_MASK = 32'h0000_FFE7;
  localparam logic [31:0] TIM_MASK  = 32'h00FF_FFFF;

  // small display, every field a length minus 1
  localparam int DIV = 1;
  localparam int HSN = 2;
  localparam int HBP = 1;
  localparam int HVL = 7;
  localparam int HFP = 1;
  localparam int VSN = 1;
  localparam int VBP = 0;
  localparam int VVL = 3;
  localparam int VFP = 0;
  localparam int LINE_CLKS  = (DIV + 1) * (HSN + HBP + HVL + HFP + 4);
  localparam int FRAME_CLKS = LINE_CLKS * (VSN + VBP + VVL + VFP + 4);

  // about 8 frames of tests, rounded up, plus slack for apb traffic
  localparam int TEST_FRAMES = 12;
  localparam int WATCHDOG_NS = (TEST_FRAMES * FRAME_CLKS + 50 * LINE_CLKS) * CLK_PERIOD;

  logic        pclk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [5:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        irq;
  logic [15:0] pixel_data;
  logic        pixel_ready;
  logic        hsync;
  logic        vsync;
  logic        de;
  logic        blank;
  logic [4:0]  vga_r;
  logic [5:0]  vga_g;
  logic [4:0]  vga_b;
  logic [31:0] rng;
  int          value_errors;
  int          other_errors;
  string       test_name;

  vga_top dut (
    .pclk_i        (pclk),
    .rst_i         (rst),
    .psel_i        (psel),
    .penable_i     (penable),
    .pwrite_i      (pwrite),
    .paddr_i       (paddr),
    .pwdata_i      (pwdata),
    .prdata_o      (prdata),
    .pready_o      (pready),
    .irq_o         (irq),
    .pixel_data_i  (pixel_data),
    .pixel_ready_o (pixel_ready),
    .hsync_o       (hsync),
    .vsync_o       (vsync),
    .de_o          (de),
    .blank_o       (blank),
    .vga_r_o       (vga_r),
    .vga_g_o       (vga_g),
    .vga_b_o       (vga_b)
  );

  always #(CLK_PERIOD / 2) pclk = ~pclk;

  ////////////////////
  // helpers
  ////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // control word from its fields
  function automatic logic [31:0] make_ctrl(input logic en, input logic hie, input logic vie,
                                            input logic blpol, input logic hspol,
                                            input logic vspol, input logic [7:0] div);
    return {16'h0000, div, vspol, hspol, blpol, 2'b00, vie, hie, en};
  endfunction

  function automatic logic [31:0] timing_word(input int sn, input int bp, input int fp);
    return {8'h00, 8'(bp), 8'(sn), 8'(fp)};
  endfunction

  function automatic logic sync_level(input logic vertical);
    return vertical ? vsync : hsync;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      value_errors++;
      $display("Error: [%s] %s expected %0h actual %0h", test_name, name, expected, actual);
    end
  endtask

  task automatic check_condition(input logic cond, input string msg);
    assert (cond === 1'b1) else begin
      other_errors++;
      $display("[%s] %s", test_name, msg);
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic apb_write(input logic [5:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge pclk);
    penable = 1'b1;
    while (pready !== 1'b1) @(negedge pclk);
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [5:0] addr, output logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge pclk);
    penable = 1'b1;
    // every access completes in its enable cycle
    #1;
    check_condition(pready === 1'b1, "pready_o is low in the enable cycle");
    while (pready !== 1'b1) @(negedge pclk);
    // prdata is combinational in the enable cycle
    #1 data = prdata;
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic reg_roundtrip(input string name, input logic [5:0] addr,
                               input logic [31:0] wdata, input logic [31:0] mask);
    logic [31:0] rd;
    apb_write(addr, wdata);
    apb_read(addr, rd);
    compare_value(name, wdata & mask, rd);
  endtask

  task automatic program_timing();
    apb_write(A_HVVL, {16'(VVL), 16'(HVL)});
    apb_write(A_HTIM, timing_word(HSN, HBP, HFP));
    apb_write(A_VTIM, timing_word(VSN, VBP, VFP));
  endtask

  // en low for two clocks restarts both timers
  task automatic start_display(input logic [31:0] ctrl);
    apb_write(A_CTRL, ctrl & ~32'h1);
    apb_write(A_CTRL, ctrl);
  endtask

  task automatic sync_wait(input logic vertical, input logic level);
    while (sync_level(vertical) !== level) @(negedge pclk);
  endtask

  task automatic irq_wait();
    while (irq !== 1'b1) @(negedge pclk);
  endtask

  // width and period in clocks of the first full pulse at the active level
  task automatic measure_pulse(input logic vertical, input logic active,
                               output int width, output int period);
    sync_wait(vertical, active);
    sync_wait(vertical, ~active);
    sync_wait(vertical, active);
    width = 0;
    while (sync_level(vertical) === active) begin
      width++;
      @(negedge pclk);
    end
    period = width;
    while (sync_level(vertical) !== active) begin
      period++;
      @(negedge pclk);
    end
  endtask

  ////////////////////
  // tests
  ////////////////////
  task automatic register_access();
    logic [31:0] rd;
    test_name = "register access";
    reg_roundtrip("ctrl all ones", A_CTRL, 32'hFFFF_FFFE, CTRL_MASK);
    reg_roundtrip("ctrl pattern", A_CTRL, 32'h0000_3318, CTRL_MASK);
    reg_roundtrip("hvvl", A_HVVL, 32'hDEAD_BEEF, 32'hFFFF_FFFF);
    reg_roundtrip("htim", A_HTIM, 32'hFFFF_FFFF, TIM_MASK);
    reg_roundtrip("vtim", A_VTIM, 32'hA5C3_3C5A, TIM_MASK);
    // no pixel ticks yet, so no flags
    apb_read(A_STAT, rd);
    compare_value("stat idle", 32'h0, rd);
    // holes swallow writes and read 0
    apb_write(6'h14, 32'hFFFF_FFFF);
    apb_read(6'h14, rd);
    compare_value("unmapped 0x14", 32'h0, rd);
    apb_read(6'h3C, rd);
    compare_value("unmapped 0x3c", 32'h0, rd);
    apb_read(A_CTRL, rd);
    compare_value("ctrl after hole write", 32'h0000_3300, rd);
  endtask

  task automatic horizontal_timing();
    logic pol;
    int   width;
    int   period;
    test_name = "horizontal timing";
    program_timing();
    for (int i = 0; i < 2; i++) begin
      pol = (i == 1);
      start_display(make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, pol, 1'b0, 8'(DIV)));
      measure_pulse(1'b0, ~pol, width, period);
      compare_value("hsync width", 32'((DIV + 1) * (HSN + 1)), 32'(width));
      compare_value("hsync period", 32'(LINE_CLKS), 32'(period));
    end
  endtask

  task automatic vertical_timing();
    logic pol;
    int   width;
    int   period;
    test_name = "vertical timing";
    for (int i = 0; i < 2; i++) begin
      pol = (i == 1);
      apb_write(A_CTRL, make_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, pol, 8'(DIV)));
      repeat (2) @(negedge pclk);
      // idle level equals the polarity bit
      compare_value("vsync idle level", 32'(pol), 32'(vsync));
      apb_write(A_CTRL, make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, pol, 8'(DIV)));
      measure_pulse(1'b1, ~pol, width, period);
      compare_value("vsync width in lines", 32'(VSN + 1), 32'(width / LINE_CLKS));
      compare_value("vsync width remainder", 32'h0, 32'(width % LINE_CLKS));
      compare_value("vsync period", 32'(FRAME_CLKS), 32'(period));
    end
  endtask

  task automatic pixel_path();
    logic        blpol;
    logic        pending;
    logic        seen_gap;
    logic [15:0] exp_pix;
    int          strobes;
    int          de_cycles;
    int          blank_bad;
    test_name = "pixel path";
    blpol     = 1'b1;
    pending   = 1'b0;
    seen_gap  = 1'b0;
    exp_pix   = '0;
    strobes   = 0;
    de_cycles = 0;
    blank_bad = 0;
    start_display(make_ctrl(1'b1, 1'b0, 1'b0, blpol, 1'b0, 1'b0, 8'(DIV)));
    // align to the start of the second frame
    sync_wait(1'b1, 1'b1);
    sync_wait(1'b1, 1'b0);
    sync_wait(1'b1, 1'b1);
    while (!(seen_gap && vsync)) begin
      if (!vsync) seen_gap = 1'b1;
      // rgb one clock after the strobe
      if (pending) begin
        compare_value("rgb565", 32'(exp_pix), {16'h0000, vga_r, vga_g, vga_b});
      end
      if (de === 1'b1) de_cycles++;
      if (blank !== (~de ^ blpol)) blank_bad++;
      pending = pixel_ready;
      if (pixel_ready) begin
        strobes++;
        rng        = xorshift32(rng);
        pixel_data = rng[15:0];
        // the last pixel of a line lands after de has dropped and shows black
        exp_pix    = (strobes % (HVL + 1) == 0) ? 16'h0000 : rng[15:0];
      end
      @(negedge pclk);
    end
    compare_value("strobes per frame", 32'((HVL + 1) * (VVL + 1)), 32'(strobes));
    compare_value("de cycles per frame", 32'((DIV + 1) * (HVL + 1) * (VVL + 1)),
                  32'(de_cycles));
    compare_value("blank against de", 32'h0, 32'(blank_bad));
  endtask

  task automatic interrupt_flags();
    logic [31:0] rd;
    test_name = "interrupts";
    apb_write(A_CTRL, make_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'(DIV)));
    apb_write(A_STAT, 32'h0);
    apb_read(A_STAT, rd);
    compare_value("flags cleared", 32'h0, {30'h0, rd[1:0]});
    check_condition(!irq, "irq_o is high with both flags clear");
    // line end sets hif
    apb_write(A_CTRL, make_ctrl(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 8'(DIV)));
    irq_wait();
    apb_read(A_STAT, rd);
    compare_value("hif after line end", 32'h1, 32'(rd[0]));
    // keep vif, clear hif well before the next line end
    apb_write(A_STAT, 32'h2);
    check_condition(!irq, "irq_o stayed high after hif was cleared");
    apb_read(A_STAT, rd);
    compare_value("hif after clear", 32'h0, 32'(rd[0]));
    // flag still sets with hie low, irq stays masked
    apb_write(A_CTRL, make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'(DIV)));
    repeat (LINE_CLKS + 2) @(negedge pclk);
    apb_read(A_STAT, rd);
    compare_value("hif with hie low", 32'h1, 32'(rd[0]));
    check_condition(!irq, "irq_o is high while hie is low");
    apb_write(A_CTRL, make_ctrl(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 8'(DIV)));
    check_condition(irq, "irq_o is low with hie and hif both set");
    // frame end sets vif
    apb_write(A_CTRL, make_ctrl(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 8'(DIV)));
    apb_write(A_STAT, 32'h0);
    irq_wait();
    apb_read(A_STAT, rd);
    compare_value("vif after frame end", 32'h1, 32'(rd[1]));
    apb_write(A_STAT, 32'h1);
    check_condition(!irq, "irq_o stayed high after vif was cleared");
    apb_read(A_STAT, rd);
    compare_value("vif after clear", 32'h0, 32'(rd[1]));
  endtask

  task automatic display_disable();
    int busy;
    int sync_bad;
    test_name = "disable";
    busy      = 0;
    sync_bad  = 0;
    start_display(make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'(DIV)));
    while (pixel_ready !== 1'b1) @(negedge pclk);
    // inverted polarities, so an idle sync reads 1
    apb_write(A_CTRL, make_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 8'(DIV)));
    // timers park, then the output registers follow
    repeat (2) @(negedge pclk);
    repeat (FRAME_CLKS) begin
      if (pixel_ready !== 1'b0 || de !== 1'b0) busy++;
      if (hsync !== 1'b1 || vsync !== 1'b1) sync_bad++;
      @(negedge pclk);
    end
    compare_value("strobe or de cycles", 32'h0, 32'(busy));
    compare_value("active sync cycles", 32'h0, 32'(sync_bad));
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    pclk         = 1'b0;
    rst          = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    pixel_data   = '0;
    rng          = SEED;
    value_errors = 0;
    other_errors = 0;
    test_name    = "reset";
    repeat (4) @(negedge pclk);
    rst = 1'b0;
    register_access();
    horizontal_timing();
    vertical_timing();
    pixel_path();
    interrupt_flags();
    display_disable();
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog sized from the frame length
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: no result after %0d ns, a test is stuck", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/vga_tb_sva.sv
// Output stage properties, bound into every vga_pixel_out instance.
// Checked on the rising clock edge, idle while reset is high.
`timescale 1ns/100ps
`default_nettype none

module vga_tb_sva (
  input logic                pclk_i,
  input logic                rst_i,
  input logic                pix_tick_i,
  input vga_pkg::axis_stat_t h_stat_i,
  input vga_pkg::axis_stat_t v_stat_i,
  input logic                pixel_ready_i,
  input logic                de_i,
  input logic [4:0]          vga_r_i,
  input logic [5:0]          vga_g_i,
  input logic [4:0]          vga_b_i
);

  // a pixel request only follows a pixel tick at a visible position
  a_ready_source: assert property (@(posedge pclk_i) disable iff (rst_i)
    pixel_ready_i |-> $past(pix_tick_i & h_stat_i.visible & v_stat_i.visible))
    else $error("pixel request without a visible pixel tick");

  // colour is black outside visible time
  a_rgb_black: assert property (@(posedge pclk_i) disable iff (rst_i)
    !de_i |-> (vga_r_i == '0 && vga_g_i == '0 && vga_b_i == '0))
    else $error("non-zero rgb while the data enable is low");

endmodule

bind vga_pixel_out vga_tb_sva u_sva (
  .pclk_i        (pclk_i),
  .rst_i         (rst_i),
  .pix_tick_i    (pix_tick_i),
  .h_stat_i      (h_stat_i),
  .v_stat_i      (v_stat_i),
  .pixel_ready_i (pixel_ready_o),
  .de_i          (de_o),
  .vga_r_i       (vga_r_o),
  .vga_g_i       (vga_g_o),
  .vga_b_i       (vga_b_o)
);

`default_nettype wire

// File: rtl/vga_top.sv
// Display controller top: APB registers, pixel divider, two axis timers
// and the output stage, all on pclk_i.
// Pixels enter on pixel_data_i, sampled while pixel_ready_o is high.
`timescale 1ns/100ps
`default_nettype none

module vga_top (
  input  logic        pclk_i,
  input  logic        rst_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [5:0]  paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        irq_o,
  input  logic [15:0] pixel_data_i,
  output logic        pixel_ready_o,
  output logic        hsync_o,
  output logic        vsync_o,
  output logic        de_o,
  output logic        blank_o,
  output logic [4:0]  vga_r_o,
  output logic [5:0]  vga_g_o,
  output logic [4:0]  vga_b_o
);
  import vga_pkg::*;

  logic                     disp_en;
  logic [DIV_W-1:0]         div;
  axis_cfg_t [N_AXES-1:0]   axis_cfg;
  axis_stat_t [N_AXES-1:0]  axis_stat;
  logic [N_AXES-1:0]        axis_step;
  disp_cfg_t                disp_cfg;
  logic                     pix_tick;
  logic                     hend;
  logic                     vend;

  vga_regs u_regs (
    .pclk_i     (pclk_i),
    .rst_i      (rst_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .hend_i     (hend),
    .vend_i     (vend),
    .irq_o      (irq_o),
    .disp_en_o  (disp_en),
    .div_o      (div),
    .axis_cfg_o (axis_cfg),
    .disp_cfg_o (disp_cfg)
  );

  vga_pclk_div u_pclk_div (
    .pclk_i     (pclk_i),
    .rst_i      (rst_i),
    .en_i       (disp_en),
    .div_i      (div),
    .pix_tick_o (pix_tick)
  );

  ////////////////////
  // axis timer chain
  ////////////////////
  for (genvar gi = 0; gi < N_AXES; gi++) begin : g_axis
    if (gi == 0) begin : g_first
      assign axis_step[gi] = pix_tick;
    end else begin : g_next
      // carry in from the end of the faster axis
      assign axis_step[gi] = axis_step[gi-1] & axis_stat[gi-1].last_o_tick;
    end

    vga_axis_timer u_timer (
      .pclk_i (pclk_i),
      .rst_i  (rst_i),
      .en_i   (disp_en),
      .step_i (axis_step[gi]),
      .cfg_i  (axis_cfg[gi]),
      .stat_o (axis_stat[gi])
    );
  end

  // line end and frame end events for the status flags
  assign hend = axis_step[AXIS_H] & axis_stat[AXIS_H].last_o_tick;
  assign vend = hend & axis_stat[AXIS_V].last_o_tick;

  vga_pixel_out u_pixel_out (
    .pclk_i        (pclk_i),
    .rst_i         (rst_i),
    .pix_tick_i    (pix_tick),
    .h_stat_i      (axis_stat[AXIS_H]),
    .v_stat_i      (axis_stat[AXIS_V]),
    .disp_cfg_i    (disp_cfg),
    .pixel_data_i  (pixel_data_i),
    .pixel_ready_o (pixel_ready_o),
    .hsync_o       (hsync_o),
    .vsync_o       (vsync_o),
    .de_o          (de_o),
    .blank_o       (blank_o),
    .vga_r_o       (vga_r_o),
    .vga_g_o       (vga_g_o),
    .vga_b_o       (vga_b_o)
  );

endmodule

`default_nettype wire

// File: rtl/vga_pixel_out.sv
// Output stage of the display controller.
// Every output is registered one clock after the timer state.
// pixel_data_i must be valid whenever pixel_ready_o is high, there is no stall.
// RGB follows the strobe by one clock and is forced to 0 outside visible time,
// so the last pixel of each line is masked by the falling data enable.
`timescale 1ns/100ps
`default_nettype none

module vga_pixel_out (
  input  logic                pclk_i,
  input  logic                rst_i,
  input  logic                pix_tick_i,
  input  vga_pkg::axis_stat_t h_stat_i,
  input  vga_pkg::axis_stat_t v_stat_i,
  input  vga_pkg::disp_cfg_t  disp_cfg_i,
  input  logic [15:0]         pixel_data_i,
  output logic                pixel_ready_o,
  output logic                hsync_o,
  output logic                vsync_o,
  output logic                de_o,
  output logic                blank_o,
  output logic [4:0]          vga_r_o,
  output logic [5:0]          vga_g_o,
  output logic [4:0]          vga_b_o
);

  logic de_next;
  logic req_next;

  assign de_next  = h_stat_i.visible & v_stat_i.visible;
  assign req_next = pix_tick_i & de_next;

  always_ff @(posedge pclk_i) begin
    if (rst_i) begin
      pixel_ready_o <= 1'b0;
      hsync_o       <= 1'b0;
      vsync_o       <= 1'b0;
      de_o          <= 1'b0;
      blank_o       <= 1'b1;
      vga_r_o       <= '0;
      vga_g_o       <= '0;
      vga_b_o       <= '0;
    end else begin
      pixel_ready_o <= req_next;
      hsync_o       <= h_stat_i.sync ^ disp_cfg_i.hspol;
      vsync_o       <= v_stat_i.sync ^ disp_cfg_i.vspol;
      de_o          <= de_next;
      blank_o       <= ~de_next ^ disp_cfg_i.blpol;
      if (!de_next) begin
        vga_r_o <= '0;
        vga_g_o <= '0;
        vga_b_o <= '0;
      end else if (pixel_ready_o) begin
        // rgb565 split
        vga_r_o <= pixel_data_i[15:11];
        vga_g_o <= pixel_data_i[10:5];
        vga_b_o <= pixel_data_i[4:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/vga_axis_timer.sv
// One display axis: sync, back porch, visible, front porch, then wrap.
// Each phase lasts its field value plus 1 steps.
// Changing the timing while enabled may give one irregular period.
// Disabled, the timer parks on its first sync tick with sync low.
`timescale 1ns/100ps
`default_nettype none

module vga_axis_timer (
  input  logic                pclk_i,
  input  logic                rst_i,
  input  logic                en_i,
  input  logic                step_i,
  input  vga_pkg::axis_cfg_t  cfg_i,
  output vga_pkg::axis_stat_t stat_o
);
  import vga_pkg::*;

  typedef enum logic [1:0] {
    PH_SYNC,
    PH_BP,
    PH_VIS,
    PH_FP
  } phase_e;

  phase_e          phase_q;
  phase_e          phase_next;
  logic [VL_W-1:0] cnt_q;
  logic [VL_W-1:0] phase_len;
  logic            phase_done;

  // length of the current phase and the one after it
  always_comb begin
    case (phase_q)
      PH_SYNC: begin
        phase_len  = VL_W'(cfg_i.sn);
        phase_next = PH_BP;
      end
      PH_BP: begin
        phase_len  = VL_W'(cfg_i.bp);
        phase_next = PH_VIS;
      end
      PH_VIS: begin
        phase_len  = cfg_i.vl;
        phase_next = PH_FP;
      end
      default: begin
        phase_len  = VL_W'(cfg_i.fp);
        phase_next = PH_SYNC;
      end
    endcase
  end

  assign phase_done = (cnt_q == phase_len);

  always_ff @(posedge pclk_i) begin
    if (rst_i || !en_i) begin
      phase_q <= PH_SYNC;
      cnt_q   <= '0;
    end else if (step_i) begin
      if (phase_done) begin
        phase_q <= phase_next;
        cnt_q   <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // internal sync is active high
  assign stat_o.sync        = en_i & (phase_q == PH_SYNC);
  assign stat_o.visible     = (phase_q == PH_VIS);
  assign stat_o.last_o_tick = (phase_q == PH_FP) & phase_done;

endmodule

`default_nettype wire

// File: rtl/vga_pclk_div.sv
// Pixel tick generator: one tick every div+1 clocks while enabled.
// The first tick comes on the first enabled clock.
`timescale 1ns/100ps
`default_nettype none

module vga_pclk_div (
  input  logic                      pclk_i,
  input  logic                      rst_i,
  input  logic                      en_i,
  input  logic [vga_pkg::DIV_W-1:0] div_i,
  output logic                      pix_tick_o
);
  import vga_pkg::*;

  logic [DIV_W-1:0] cnt_q;

  // down counter, reload from div on zero
  always_ff @(posedge pclk_i) begin
    if (rst_i || !en_i) begin
      cnt_q <= '0;
    end else if (cnt_q == '0) begin
      cnt_q <= div_i;
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign pix_tick_o = en_i & (cnt_q == '0);

endmodule

`default_nettype wire

// File: rtl/vga_regs.sv
// APB register file of the display controller.
// pready_o is tied high, so every access completes in its enable cycle.
// Reserved bits of CTRL, HTIM and VTIM are dropped on write and read as 0.
// STAT flags are sticky: writing 0 clears a flag, and a new event in the
// same cycle wins over the clear.
`timescale 1ns/100ps
`default_nettype none

module vga_regs (
  input  logic                                     pclk_i,
  input  logic                                     rst_i,
  input  logic                                     psel_i,
  input  logic                                     penable_i,
  input  logic                                     pwrite_i,
  input  logic [5:0]                               paddr_i,
  input  logic [31:0]                              pwdata_i,
  output logic [31:0]                              prdata_o,
  output logic                                     pready_o,
  input  logic                                     hend_i,
  input  logic                                     vend_i,
  output logic                                     irq_o,
  output logic                                     disp_en_o,
  output logic [vga_pkg::DIV_W-1:0]                div_o,
  output vga_pkg::axis_cfg_t [vga_pkg::N_AXES-1:0] axis_cfg_o,
  output vga_pkg::disp_cfg_t                       disp_cfg_o
);
  import vga_pkg::*;

  logic [3:0]  addr;
  logic        wr_en;
  logic        rd_en;
  logic        stat_wr;
  apb_word_u   wr_word;
  ctrl_reg_t   ctrl_q;
  ctrl_reg_t   ctrl_d;
  tim_reg_t    tim_d;
  tim_reg_t    htim_q;
  tim_reg_t    vtim_q;
  logic [31:0] hvvl_q;
  logic        hif_q;
  logic        vif_q;
  logic        hif_d;
  logic        vif_d;

  assign addr     = paddr_i[5:2];
  assign wr_en    = psel_i & penable_i & pwrite_i;
  assign rd_en    = psel_i & penable_i & ~pwrite_i;
  assign stat_wr  = wr_en & (addr == ADDR_STAT);
  assign pready_o = 1'b1;
  assign wr_word  = pwdata_i;

  ////////////////////
  // write decode
  ////////////////////
  always_comb begin
    // keep only the defined control fields
    ctrl_d       = '0;
    ctrl_d.en    = wr_word.ctrl.en;
    ctrl_d.hie   = wr_word.ctrl.hie;
    ctrl_d.vie   = wr_word.ctrl.vie;
    ctrl_d.blpol = wr_word.ctrl.blpol;
    ctrl_d.hspol = wr_word.ctrl.hspol;
    ctrl_d.vspol = wr_word.ctrl.vspol;
    ctrl_d.div   = wr_word.ctrl.div;
    // timing word, top byte unused
    tim_d        = wr_word.tim;
    tim_d.rsvd   = '0;
  end

  // sticky flags, a pwdata bit of 1 keeps the flag
  assign hif_d = hend_i | (hif_q & ~(stat_wr & ~pwdata_i[0]));
  assign vif_d = vend_i | (vif_q & ~(stat_wr & ~pwdata_i[1]));

  always_ff @(posedge pclk_i) begin
    if (rst_i) begin
      ctrl_q <= '0;
      hvvl_q <= '0;
      htim_q <= '0;
      vtim_q <= '0;
      hif_q  <= 1'b0;
      vif_q  <= 1'b0;
    end else begin
      hif_q <= hif_d;
      vif_q <= vif_d;
      if (wr_en) begin
        case (addr)
          ADDR_CTRL: ctrl_q <= ctrl_d;
          ADDR_HVVL: hvvl_q <= wr_word.raw;
          ADDR_HTIM: htim_q <= tim_d;
          ADDR_VTIM: vtim_q <= tim_d;
          default: ;
        endcase
      end
    end
  end

  ////////////////////
  // read mux
  ////////////////////
  always_comb begin
    prdata_o = '0;
    if (rd_en) begin
      case (addr)
        ADDR_CTRL: prdata_o = ctrl_q;
        ADDR_HVVL: prdata_o = hvvl_q;
        ADDR_HTIM: prdata_o = htim_q;
        ADDR_VTIM: prdata_o = vtim_q;
        ADDR_STAT: prdata_o = {30'd0, vif_q, hif_q};
        default:   prdata_o = '0;
      endcase
    end
  end

  assign irq_o = (ctrl_q.hie & hif_q) | (ctrl_q.vie & vif_q);

  // config fanout to divider, timers and output stage
  assign disp_en_o  = ctrl_q.en;
  assign div_o      = ctrl_q.div;
  assign disp_cfg_o = '{hspol: ctrl_q.hspol, vspol: ctrl_q.vspol, blpol: ctrl_q.blpol};

  // hvl in the low half, vvl in the high half
  assign axis_cfg_o[AXIS_H] = '{sn: htim_q.sn, bp: htim_q.bp, fp: htim_q.fp,
                                vl: hvvl_q[VL_W-1:0]};
  assign axis_cfg_o[AXIS_V] = '{sn: vtim_q.sn, bp: vtim_q.bp, fp: vtim_q.fp,
                                vl: hvvl_q[2*VL_W-1:VL_W]};

endmodule

`default_nettype wire

// File: rtl/vga_pkg.sv
// Shared constants and types for the display controller.
// Register indices are word addresses taken from paddr[5:2].
// Porch and sync fields hold the phase length minus 1.
// Visible lengths are 16 bits wide, so they are limited to 65536 ticks per axis.
`default_nettype none

package vga_pkg;

  ////////////////////
  // register map
  ////////////////////
  localparam logic [3:0] ADDR_CTRL = 4'd0;
  localparam logic [3:0] ADDR_HVVL = 4'd1;
  localparam logic [3:0] ADDR_HTIM = 4'd2;
  localparam logic [3:0] ADDR_VTIM = 4'd3;
  localparam logic [3:0] ADDR_STAT = 4'd4;

  // field widths
  localparam int TB_W  = 8;
  localparam int VL_W  = 16;
  localparam int DIV_W = 8;

  // axis indices into the timer array
  localparam int N_AXES = 2;
  localparam int AXIS_H = 0;
  localparam int AXIS_V = 1;

  ////////////////////
  // register words
  ////////////////////
  typedef struct packed {
    logic [15:0]      rsvd_hi;
    logic [DIV_W-1:0] div;
    logic             vspol;
    logic             hspol;
    logic             blpol;
    logic [1:0]       rsvd_lo;
    logic             vie;
    logic             hie;
    logic             en;
  } ctrl_reg_t;

  typedef struct packed {
    logic [7:0]      rsvd;
    logic [TB_W-1:0] bp;
    logic [TB_W-1:0] sn;
    logic [TB_W-1:0] fp;
  } tim_reg_t;

  // one apb write word, seen as control or timing fields by address
  typedef union packed {
    logic [31:0] raw;
    ctrl_reg_t   ctrl;
    tim_reg_t    tim;
  } apb_word_u;

  ////////////////////
  // datapath bundles
  ////////////////////
  typedef struct packed {
    logic [TB_W-1:0] sn;
    logic [TB_W-1:0] bp;
    logic [TB_W-1:0] fp;
    logic [VL_W-1:0] vl;
  } axis_cfg_t;

  typedef struct packed {
    logic sync;
    logic visible;
    logic last_o_tick;
  } axis_stat_t;

  typedef struct packed {
    logic hspol;
    logic vspol;
    logic blpol;
  } disp_cfg_t;

endpackage

`default_nettype wire
